// File: alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_consts.svh"

module alu import rv_core_pkg::*; (
  input  logic [`XLEN-1:0] operand_a,
  input  logic [`XLEN-1:0] operand_b,
  input  alu_op_e          alu_op,
  output logic [`XLEN-1:0] result
);

  // high for subtract
  logic             sub;
  // operand b, inverted for subtract
  logic [`XLEN-1:0] b_eff;

  assign sub = (alu_op == ALU_SUB);

  // one adder for both ops
  // a - b = a + ~b + 1, carry-in supplies the +1
  assign b_eff = operand_b ^ {`XLEN{sub}};

  // carry out dropped, wraps mod 2^xlen
  assign result = operand_a + b_eff + {{(`XLEN-1){1'b0}}, sub};

  // an x here would silently pick add
  always_comb begin
    assert final (!$isunknown(alu_op))
      else $error("alu_op is unknown");
  end

endmodule

`default_nettype wire

// File: inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_consts.svh"

module inst_decoder import rv_core_pkg::*; (
  input  logic [`INST_W-1:0]   inst,
  output logic [`REG_ID_W-1:0] rs1,
  output logic [`REG_ID_W-1:0] rs2,
  output logic [`REG_ID_W-1:0] rd,
  output logic [`XLEN-1:0]     imm,
  output opcode_e              opcode,
  output alu_op_e              alu_op,
  output src_a_e               src_a,
  output logic                 use_imm,
  output logic                 reg_write,
  output logic                 is_ebreak,
  output logic                 is_illegal
);

  // raw instruction fields
  logic [6:0]       opc;
  logic [2:0]       funct3;
  logic [6:0]       funct7;

  // both immediate formats, sign-extended to xlen
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_u;

  assign opc    = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // register fields sit at fixed positions in every format
  assign rd  = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  // i-type, 12 bits from inst[31:20]
  assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};

  // u-type, upper 20 bits, low 12 zero
  // rv64 sign-extends bit 31 into the upper word
  assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};

  // classify into one instruction class
  always_comb begin
    opcode = OP_ILLEGAL;
    case (opc)
      `OPC_OP: begin
        if (funct3 == `FUNCT3_ADD) begin
          if (funct7 == `FUNCT7_ADD) begin
            opcode = OP_ADD;
          end else if (funct7 == `FUNCT7_SUB) begin
            opcode = OP_SUB;
          end
        end
      end
      `OPC_OP_IMM: begin
        // only addi, other funct3 values stay illegal
        if (funct3 == `FUNCT3_ADD) begin
          opcode = OP_ADDI;
        end
      end
      `OPC_LUI: begin
        opcode = OP_LUI;
      end
      `OPC_AUIPC: begin
        opcode = OP_AUIPC;
      end
      `OPC_SYSTEM: begin
        // ecall, csr ops and friends fall through to illegal
        if (inst == `EBREAK_INST) begin
          opcode = OP_EBREAK;
        end
      end
      default: begin
        opcode = OP_ILLEGAL;
      end
    endcase
  end

  // control signals from the class
  always_comb begin
    alu_op    = ALU_ADD;
    src_a     = SRC_A_REG;
    use_imm   = 1'b0;
    reg_write = 1'b0;
    imm       = imm_i;
    case (opcode)
      OP_ADD: begin
        reg_write = 1'b1;
      end
      OP_SUB: begin
        alu_op    = ALU_SUB;
        reg_write = 1'b1;
      end
      OP_ADDI: begin
        use_imm   = 1'b1;
        reg_write = 1'b1;
      end
      OP_LUI: begin
        // 0 + imm_u
        src_a     = SRC_A_ZERO;
        use_imm   = 1'b1;
        imm       = imm_u;
        reg_write = 1'b1;
      end
      OP_AUIPC: begin
        src_a     = SRC_A_PC;
        use_imm   = 1'b1;
        imm       = imm_u;
        reg_write = 1'b1;
      end
      // ebreak and illegal leave reg_write low
      default: begin
        reg_write = 1'b0;
      end
    endcase
  end

  assign is_ebreak  = (opcode == OP_EBREAK);
  assign is_illegal = (opcode == OP_ILLEGAL);

  // every known word lands in exactly one outcome
  always_comb begin
    if (!$isunknown(inst)) begin
      assert final ($onehot({reg_write, is_ebreak, is_illegal}))
        else $error("decoder outcome not one-hot for inst %h", inst);
    end
  end

endmodule

`default_nettype wire

// File: pc_reg.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_consts.svh"

module pc_reg (
  input  logic             clk,
  input  logic             rst,
  input  logic             halt_req,
  output logic [`XLEN-1:0] current_pc,
  output logic [`XLEN-1:0] next_pc
  ,
  output logic             halted
);

  // sequential fetch only, no branch target
  assign next_pc = current_pc + `XLEN'd4;

  // pc and halt flag
  // the ebreak edge still advances the pc
  // the freeze starts one edge later once halted is set
  always_ff @(posedge clk) begin
    if (rst) begin
      current_pc <= `RESET_PC;
      halted     <= 1'b0;
    end else if (!halted) begin
      current_pc <= next_pc;
      if (halt_req) begin
        halted <= 1'b1;
      end
    end
  end

  // reset pc is aligned and every step is +4
  pc_aligned_a: assert property (
    @(posedge clk) disable iff (rst)
    current_pc[1:0] == 2'b00
  ) else $error("pc misaligned: %h", current_pc);

endmodule

`default_nettype wire

// File: register_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_consts.svh"

module register_file (
  input  logic                 clk,
  input  logic                 wen,
  input  logic [`REG_ID_W-1:0] rd,
  input  logic [`REG_ID_W-1:0] rs1,
  input  logic [`REG_ID_W-1:0] rs2,
  input  logic [`XLEN-1:0]     wdata,
  output logic [`XLEN-1:0]     rdata_1,
  output logic [`XLEN-1:0]     rdata_2
);

  localparam int NUM_REGS = 1 << `REG_ID_W;

  // entry 0 is never written
  logic [`XLEN-1:0] regs [NUM_REGS];

  // single write port, takes effect at the edge
  // x0 writes dropped here so the top needs no rd check
  always_ff @(posedge clk) begin
    if (wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // async read port 1
  // x0 forced to zero rather than relying on storage
  always_comb begin
    if (rs1 == '0) begin
      rdata_1 = '0;
    end else begin
      rdata_1 = regs[rs1];
    end
  end

  // async read port 2
  always_comb begin
    if (rs2 == '0) begin
      rdata_2 = '0;
    end else begin
      rdata_2 = regs[rs2];
    end
  end

  // no bypass from the write port
  // single-cycle core, write lands before the next read anyway

endmodule

`default_nettype wire

// File: rv_core.f
+incdir+.
rv_core_pkg.sv
inst_decoder.sv
register_file.sv
alu.sv
pc_reg.sv
rv_core.sv
tb_clock_gen.sv
rv_core_tb.sv

// File: rv_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_core import rv_core_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`INST_W-1:0]   inst,
  output logic [`XLEN-1:0]     current_pc,
  output logic [`XLEN-1:0]     next_pc,
  output logic                 retire_valid,
  output logic [`REG_ID_W-1:0] retire_rd,
  output logic [`XLEN-1:0]     retire_data,
  output logic                 illegal,
  output logic                 halted
);

  // decode outputs
  logic [`REG_ID_W-1:0] rs1;
  logic [`REG_ID_W-1:0] rs2;
  logic [`REG_ID_W-1:0] rd;
  logic [`XLEN-1:0]     imm;
  opcode_e              opcode;
  alu_op_e              alu_op;
  src_a_e               src_a;
  logic                 use_imm;
  logic                 reg_write;
  logic                 is_ebreak;
  logic                 is_illegal;

  // execute datapath
  logic [`XLEN-1:0]     rdata_1;
  logic [`XLEN-1:0]     rdata_2;
  logic [`XLEN-1:0]     operand_a;
  logic [`XLEN-1:0]     operand_b;
  logic [`XLEN-1:0]     result;
  logic                 wen;

  inst_decoder u_inst_decoder (
    .inst       (inst),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .imm        (imm),
    .opcode     (opcode),
    .alu_op     (alu_op),
    .src_a      (src_a),
    .use_imm    (use_imm),
    .reg_write  (reg_write),
    .is_ebreak  (is_ebreak),
    .is_illegal (is_illegal)
  );

  // operand a, reg / pc / zero
  always_comb begin
    case (src_a)
      SRC_A_PC:   operand_a = current_pc;
      SRC_A_ZERO: operand_a = '0;
      default:    operand_a = rdata_1;
    endcase
  end

  // operand b, immediate or rs2
  assign operand_b = use_imm ? imm : rdata_2;

  alu u_alu (
    .operand_a (operand_a),
    .operand_b (operand_b),
    .alu_op    (alu_op),
    .result    (result)
  );

  // retire only when running and out of reset
  assign retire_valid = reg_write && !halted && !rst;
  // same condition gates the write port
  assign wen          = retire_valid;

  register_file u_register_file (
    .clk     (clk),
    .wen     (wen),
    .rd      (rd),
    .rs1     (rs1),
    .rs2     (rs2),
    .wdata   (result),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  // ebreak requests the freeze
  pc_reg u_pc_reg (
    .clk        (clk),
    .rst        (rst),
    .halt_req   (is_ebreak),
    .current_pc (current_pc),
    .next_pc    (next_pc),
    .halted     (halted)
  );

  // retire trace
  assign retire_rd   = rd;
  assign retire_data = result;
  // no illegal reports after the halt
  assign illegal     = is_illegal && !halted;

  // decoded ebreak must land in the pc register's halt flag
  ebreak_halts_a: assert property (
    @(posedge clk) disable iff (rst)
    (opcode == OP_EBREAK && !halted) |=> halted
  ) else $error("ebreak did not halt the core");

  // once halted the pc stays put
  halt_freezes_pc_a: assert property (
    @(posedge clk) disable iff (rst)
    halted |=> $stable(current_pc)
  ) else $error("pc moved while halted");

endmodule

`default_nettype wire

// File: rv_core_consts.svh
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// datapath and pc width
`define XLEN 64

// one fetched instruction
`define INST_W 32

// architectural register index
`define REG_ID_W 5

// first fetch address after reset
`define RESET_PC 64'h80000000

// major opcodes, bits [6:0]
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_SYSTEM 7'b1110011

// funct3 shared by add, sub and addi
`define FUNCT3_ADD 3'b000

// funct7 for add vs sub in the OP group
`define FUNCT7_ADD 7'b0000000
`define FUNCT7_SUB 7'b0100000

// ebreak is matched on the whole word
`define EBREAK_INST 32'h00100073

`endif

// File: rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  // decoded instruction class
  // one value per supported instruction plus a catch-all
  typedef enum logic [2:0] {
    OP_ADD     = 3'd0,
    OP_SUB     = 3'd1,
    OP_ADDI    = 3'd2,
    OP_LUI     = 3'd3,
    OP_AUIPC   = 3'd4,
    OP_EBREAK  = 3'd5,
    OP_ILLEGAL = 3'd6
  } opcode_e;

  // alu function
  // only add and sub needed by this subset
  typedef enum logic {
    ALU_ADD = 1'b0,
    ALU_SUB = 1'b1
  } alu_op_e;

  // where operand a comes from
  // reg for add/sub/addi, pc for auipc
  // zero for lui so the adder passes the immediate
  typedef enum logic [1:0] {
    SRC_A_REG  = 2'd0,
    SRC_A_PC   = 2'd1,
    SRC_A_ZERO = 2'd2
  } src_a_e;

endpackage

`default_nettype wire

// File: rv_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_core_tb;

  // load major opcode, outside the supported set
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam int         MAX_CYCLES = 400;

  typedef enum int {K_ADD, K_SUB, K_ADDI, K_LUI, K_AUIPC, K_EBREAK, K_ILLEGAL} inst_kind_e;

  logic                 clk;
  logic                 rst;
  logic [`INST_W-1:0]   inst;
  logic [`XLEN-1:0]     current_pc;
  logic [`XLEN-1:0]     next_pc;
  logic                 retire_valid;
  logic [`REG_ID_W-1:0] retire_rd;
  logic [`XLEN-1:0]     retire_data;
  logic                 illegal;
  logic                 halted;

  // fields of the instruction on inst right now
  inst_kind_e           cur_kind;
  logic [4:0]           cur_rd;
  logic [4:0]           cur_rs1;
  logic [4:0]           cur_rs2;
  logic [19:0]          cur_raw;
  logic [4:0]           last_rd;

  // reference state
  logic [`XLEN-1:0]     mirror [32];
  logic [`XLEN-1:0]     exp_pc;
  logic                 exp_halted;
  logic [`XLEN-1:0]     exp_result;
  logic                 exp_valid;
  logic                 exp_illegal;
  logic                 checks_on;
  int                   cycle_count;

  tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(10)) u_clock_gen (.clk(clk), .rst(rst));

  rv_core UUT (
    .clk          (clk),
    .rst          (rst),
    .inst         (inst),
    .current_pc   (current_pc),
    .next_pc      (next_pc),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .illegal      (illegal),
    .halted       (halted)
  );

  // expected write-back from the instruction rules
  always_comb begin
    case (cur_kind)
      K_ADD:   exp_result = mirror[cur_rs1] + mirror[cur_rs2];
      K_SUB:   exp_result = mirror[cur_rs1] - mirror[cur_rs2];
      K_ADDI:  exp_result = mirror[cur_rs1] + {{52{cur_raw[11]}}, cur_raw[11:0]};
      K_LUI:   exp_result = {{32{cur_raw[19]}}, cur_raw, 12'b0};
      K_AUIPC: exp_result = exp_pc + {{32{cur_raw[19]}}, cur_raw, 12'b0};
      default: exp_result = '0;
    endcase
    exp_valid   = (cur_kind inside {K_ADD, K_SUB, K_ADDI, K_LUI, K_AUIPC}) && !exp_halted && !rst;
    exp_illegal = (cur_kind == K_ILLEGAL) && !exp_halted;
  end

  // reference pc, halt flag and register mirror
  // x0 entry is never written, stays zero
  always @(posedge clk) begin
    checks_on <= 1'b1;
    if (rst) begin
      exp_pc     <= `RESET_PC;
      exp_halted <= 1'b0;
    end else if (!exp_halted) begin
      exp_pc <= exp_pc + 64'd4;
      if (cur_kind == K_EBREAK) begin
        exp_halted <= 1'b1;
      end
    end
    if (exp_valid && cur_rd != 5'd0) begin
      mirror[cur_rd] <= exp_result;
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("FAILED %s expected %h actual %h", name, exp, act);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  // first edge skipped, pc and halted still unknown before it
  pc_a: assert property (@(posedge clk) checks_on |-> current_pc == exp_pc)
    else report_mismatch("current_pc", $sampled(exp_pc), $sampled(current_pc));
  next_pc_a: assert property (@(posedge clk) checks_on |-> next_pc == exp_pc + 64'd4)
    else report_mismatch("next_pc", $sampled(exp_pc) + 64'd4, $sampled(next_pc));
  halted_a: assert property (@(posedge clk) checks_on |-> halted == exp_halted)
    else report_mismatch("halted", $sampled(exp_halted), $sampled(halted));
  valid_a: assert property (@(posedge clk) checks_on |-> retire_valid == exp_valid)
    else report_mismatch("retire_valid", $sampled(exp_valid), $sampled(retire_valid));
  rd_a: assert property (@(posedge clk) checks_on && exp_valid |-> retire_rd == cur_rd)
    else report_mismatch("retire_rd", $sampled(cur_rd), $sampled(retire_rd));
  data_a: assert property (@(posedge clk) checks_on && exp_valid |-> retire_data == exp_result)
    else report_mismatch("retire_data", $sampled(exp_result), $sampled(retire_data));
  illegal_a: assert property (@(posedge clk) checks_on |-> illegal == exp_illegal)
    else report_mismatch("illegal", $sampled(exp_illegal), $sampled(illegal));

  // encode one instruction and put it on inst at the falling edge
  task automatic issue(input inst_kind_e kind, input logic [4:0] rd, input logic [4:0] rs1,
                       input logic [4:0] rs2, input logic [19:0] raw);
    logic [31:0] word;
    case (kind)
      K_ADD:    word = {`FUNCT7_ADD, rs2, rs1, `FUNCT3_ADD, rd, `OPC_OP};
      K_SUB:    word = {`FUNCT7_SUB, rs2, rs1, `FUNCT3_ADD, rd, `OPC_OP};
      K_ADDI:   word = {raw[11:0], rs1, `FUNCT3_ADD, rd, `OPC_OP_IMM};
      K_LUI:    word = {raw, rd, `OPC_LUI};
      K_AUIPC:  word = {raw, rd, `OPC_AUIPC};
      K_EBREAK: word = `EBREAK_INST;
      default:  word = {raw, rd, OPC_LOAD};
    endcase
    @(negedge clk);
    inst     = word;
    cur_kind = kind;
    cur_rd   = rd;
    cur_rs1  = rs1;
    cur_rs2  = rs2;
    cur_raw  = raw;
    if (kind inside {K_ADD, K_SUB, K_ADDI, K_LUI, K_AUIPC}) begin
      last_rd = rd;
    end
  endtask

  // one random instruction, now and then chained on the last result
  task automatic issue_random();
    int          k;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [19:0] raw;
    k   = int'($urandom % 16);
    rd  = ($urandom % 8 == 0) ? 5'd0 : 5'($urandom % 32);
    rs1 = ($urandom % 4 == 0) ? last_rd : 5'($urandom % 32);
    rs2 = ($urandom % 4 == 0) ? last_rd : 5'($urandom % 32);
    raw = 20'($urandom);
    if (k < 4) issue(K_ADD, rd, rs1, rs2, raw);
    else if (k < 7) issue(K_SUB, rd, rs1, rs2, raw);
    else if (k < 10) issue(K_ADDI, rd, rs1, rs2, raw);
    else if (k < 12) issue(K_LUI, rd, rs1, rs2, raw);
    else if (k < 15) issue(K_AUIPC, rd, rs1, rs2, raw);
    else issue(K_ILLEGAL, rd, rs1, rs2, raw);
  endtask

  // run limit, about 250 cycles expected
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  end

  initial begin
    void'($urandom(32'h93f9));
    cycle_count = 0;
    checks_on   = 1'b0;
    last_rd     = 5'd0;
    for (int i = 0; i < 32; i++) begin
      mirror[i] = '0;
    end
    // a writing lui held through reset, must not retire
    inst     = {20'habcde, 5'd1, `OPC_LUI};
    cur_kind = K_LUI;
    cur_rd   = 5'd1;
    cur_rs1  = 5'd0;
    cur_rs2  = 5'd0;
    cur_raw  = 20'habcde;
    wait (rst == 1'b0);
    // reset drops on a falling edge
    // illegal word for the first cycle after it
    inst     = {25'h1abcd, OPC_LOAD};
    cur_kind = K_ILLEGAL;
    cur_rd   = 5'd0;
    cur_raw  = 20'd0;
    // preamble fills every register, lui on odd, addi from x0 on even
    for (int r = 1; r < 32; r++) begin
      if (r % 2 == 1) issue(K_LUI, 5'(r), 5'd0, 5'd0, 20'($urandom));
      else issue(K_ADDI, 5'(r), 5'd0, 5'd0, 20'($urandom));
    end
    repeat (200) issue_random();
    issue(K_EBREAK, 5'd0, 5'd0, 5'd0, 20'd0);
    // after the halt nothing may retire or flag illegal
    repeat (4) issue_random();
    issue(K_ILLEGAL, 5'd3, 5'd0, 5'd0, 20'h5a5a5);
    @(negedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst
);

  // free-running clock, low at time zero
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset high from the start, released on a falling edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire
